// ==== logic/rvConsts.svh ====
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// data path, address and instruction width.
`define RV_XLEN 32

// architectural registers, x0 included.
`define RV_NUM_REGS 32

// first fetch address once rst drops.
`define RV_RESET_PC 32'h0000_0000

// addi x0, x0, 0.
`define RV_NOP 32'h0000_0013

`endif

// ==== logic/rvPkg.sv ====
`default_nettype none

`include "rvConsts.svh"

package rvPkg;

    typedef logic [`RV_XLEN-1:0] wordT;
    typedef logic [$clog2(`RV_NUM_REGS)-1:0] regAddrT;

    // only the major opcodes this core executes.
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111
    } opcodeT;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluSll,
        aluSlt,
        aluSltu,
        aluXor,
        aluSrl,
        aluSra,
        aluOr,
        aluAnd,
        aluPassB // hands operand B through, used by LUI.
    } aluOpT;

endpackage

`default_nettype wire

// ==== logic/stageIf.sv ====
`timescale 1ns/1ps
`default_nettype none

// ID/EX register contents as seen by execute.
interface decodeExecIf import rvPkg::*; ();
    logic    valid;
    wordT    pc;
    regAddrT rs1;
    regAddrT rs2;
    wordT    rs1Val;
    wordT    rs2Val;
    wordT    imm;
    regAddrT rd;
    aluOpT   aluOp;
    logic    useImm;
    logic    useRs1Pc;
    logic    isLoad;
    logic    isStore;
    logic    isBranch;
    logic    branchOnNotEqual;
    logic    isJal;
    logic    regWrite;
    logic    flush; // taken branch or jump in execute.

    modport decode (
        output valid, pc, rs1, rs2, rs1Val, rs2Val, imm, rd, aluOp, useImm, useRs1Pc,
               isLoad, isStore, isBranch, branchOnNotEqual, isJal, regWrite,
        input  flush
    );

    modport exec (
        input  valid, pc, rs1, rs2, rs1Val, rs2Val, imm, rd, aluOp, useImm, useRs1Pc,
               isLoad, isStore, isBranch, branchOnNotEqual, isJal, regWrite,
        output flush
    );
endinterface

// EX/MEM register contents as seen by the memory stage.
interface execMemIf import rvPkg::*; ();
    logic    valid;
    wordT    pc;
    regAddrT rd;
    logic    regWrite;
    logic    isLoad;
    logic    isStore;
    wordT    result;    // ALU result, also the load/store address.
    wordT    storeData;

    modport exec (output valid, pc, rd, regWrite, isLoad, isStore, result, storeData);
    modport mem (input valid, pc, rd, regWrite, isLoad, isStore, result, storeData);
endinterface

`default_nettype wire

// ==== logic/fetchStage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rvConsts.svh"

module fetchStage import rvPkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic stall,
    input  logic redirectValid,
    input  wordT redirectPc,
    output wordT imemAddr,
    input  wordT imemData,
    output wordT fetchPc,
    output wordT fetchInst,
    output logic fetchValid
);

    wordT pc;

    // the first cycle after reset only presents the reset address.
    always_ff @(posedge clk) begin
        if (rst) begin
            fetchValid <= 1'b0;
        end else begin
            fetchValid <= 1'b1;
        end
    end

    // a redirect wins over a stall.
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `RV_RESET_PC;
        end else if (redirectValid) begin
            pc <= redirectPc;
        end else if (!stall && fetchValid) begin
            pc <= pc + wordT'(4);
        end
    end

    assign imemAddr  = pc;
    assign fetchPc   = pc;
    assign fetchInst = imemData; // instruction memory reads combinationally.

endmodule

`default_nettype wire

// ==== logic/decodeStage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rvConsts.svh"

module decodeStage import rvPkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  wordT    fetchPc,
    input  wordT    fetchInst,
    input  logic    fetchValid,
    output logic    stall,
    input  logic    redirectValid,
    input  logic    wbWen,
    input  regAddrT wbRd,
    input  wordT    wbData,
    decodeExecIf.decode toExec
);

    wordT    ifIdPc;
    wordT    ifIdInst;
    logic    ifIdValid;
    wordT    regFile [`RV_NUM_REGS];
    opcodeT  opcode;
    logic [2:0] funct3;
    regAddrT rs1;
    regAddrT rs2;
    regAddrT rd;
    wordT    rs1Val;
    wordT    rs2Val;
    wordT    imm;
    aluOpT   aluOp;
    logic    useRs1;
    logic    useRs2;
    logic    useImm;
    logic    useRs1Pc;
    logic    isLoad;
    logic    isStore;
    logic    isBranch;
    logic    isJal;
    logic    regWrite;
    logic    insertBubble;

    function automatic aluOpT aluFromFunct(input logic [2:0] f3, input logic alt,
                                           input logic isReg);
        case (f3)
            3'b000:  return (alt && isReg) ? aluSub : aluAdd;
            3'b001:  return aluSll;
            3'b010:  return aluSlt;
            3'b011:  return aluSltu;
            3'b100:  return aluXor;
            3'b101:  return alt ? aluSra : aluSrl;
            3'b110:  return aluOr;
            default: return aluAnd;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (rst || redirectValid) begin
            ifIdValid <= 1'b0;
        end else if (!stall) begin
            ifIdValid <= fetchValid;
        end
    end

    always_ff @(posedge clk) begin
        if (redirectValid) begin
            ifIdInst <= `RV_NOP; // squashed slot decodes as a harmless addi.
        end else if (!stall) begin
            ifIdInst <= fetchInst;
            ifIdPc   <= fetchPc;
        end
    end

    assign opcode = opcodeT'(ifIdInst[6:0]);
    assign funct3 = ifIdInst[14:12];
    assign rs1    = ifIdInst[19:15];
    assign rs2    = ifIdInst[24:20];
    assign rd     = ifIdInst[11:7];

    always_comb begin
        aluOp    = aluAdd;
        imm      = '0;
        useRs1   = 1'b0;
        useRs2   = 1'b0;
        useImm   = 1'b0;
        useRs1Pc = 1'b0;
        isLoad   = 1'b0;
        isStore  = 1'b0;
        isBranch = 1'b0;
        isJal    = 1'b0;
        regWrite = 1'b0;
        case (opcode)
            OP: begin
                aluOp    = aluFromFunct(funct3, ifIdInst[30], 1'b1);
                useRs1   = 1'b1;
                useRs2   = 1'b1;
                regWrite = 1'b1;
            end
            OP_IMM: begin
                aluOp    = aluFromFunct(funct3, ifIdInst[30], 1'b0);
                imm      = {{20{ifIdInst[31]}}, ifIdInst[31:20]};
                useRs1   = 1'b1;
                useImm   = 1'b1;
                regWrite = 1'b1;
            end
            LUI, AUIPC: begin
                aluOp    = (opcode == LUI) ? aluPassB : aluAdd;
                imm      = {ifIdInst[31:12], 12'b0};
                useImm   = 1'b1;
                useRs1Pc = (opcode == AUIPC);
                regWrite = 1'b1;
            end
            LOAD: begin
                imm      = {{20{ifIdInst[31]}}, ifIdInst[31:20]};
                useRs1   = 1'b1;
                useImm   = 1'b1;
                isLoad   = 1'b1;
                regWrite = 1'b1;
            end
            STORE: begin
                imm     = {{20{ifIdInst[31]}}, ifIdInst[31:25], ifIdInst[11:7]};
                useRs1  = 1'b1;
                useRs2  = 1'b1;
                useImm  = 1'b1;
                isStore = 1'b1;
            end
            BRANCH: begin
                imm = {{19{ifIdInst[31]}}, ifIdInst[31], ifIdInst[7], ifIdInst[30:25],
                       ifIdInst[11:8], 1'b0};
                useRs1   = 1'b1;
                useRs2   = 1'b1;
                isBranch = (funct3[2:1] == 2'b00); // only BEQ and BNE.
            end
            JAL: begin
                imm = {{11{ifIdInst[31]}}, ifIdInst[31], ifIdInst[19:12], ifIdInst[20],
                       ifIdInst[30:21], 1'b0};
                isJal    = 1'b1;
                regWrite = 1'b1;
            end
            default: begin
            end
        endcase
    end

    // the write-back value of this same cycle wins over the stored entry.
    assign rs1Val = (rs1 == '0) ? '0 : (wbWen && wbRd == rs1) ? wbData : regFile[rs1];
    assign rs2Val = (rs2 == '0) ? '0 : (wbWen && wbRd == rs2) ? wbData : regFile[rs2];

    always_ff @(posedge clk) begin
        if (wbWen) begin
            regFile[wbRd] <= wbData;
        end
    end

    // a load in execute can't forward in time, so hold the consumer one cycle.
    assign stall = ifIdValid && toExec.valid && toExec.isLoad && toExec.rd != '0
                   && ((useRs1 && toExec.rd == rs1) || (useRs2 && toExec.rd == rs2));

    assign insertBubble = stall || toExec.flush || !ifIdValid;

    always_ff @(posedge clk) begin
        if (rst || insertBubble) begin
            toExec.valid    <= 1'b0;
            toExec.isLoad   <= 1'b0;
            toExec.isStore  <= 1'b0;
            toExec.isBranch <= 1'b0;
            toExec.isJal    <= 1'b0;
            toExec.regWrite <= 1'b0;
        end else begin
            toExec.valid    <= 1'b1;
            toExec.isLoad   <= isLoad;
            toExec.isStore  <= isStore;
            toExec.isBranch <= isBranch;
            toExec.isJal    <= isJal;
            toExec.regWrite <= regWrite;
        end
    end

    always_ff @(posedge clk) begin
        toExec.pc               <= ifIdPc;
        toExec.rs1              <= rs1;
        toExec.rs2              <= rs2;
        toExec.rs1Val           <= rs1Val;
        toExec.rs2Val           <= rs2Val;
        toExec.imm              <= imm;
        toExec.rd               <= rd;
        toExec.aluOp            <= aluOp;
        toExec.useImm           <= useImm;
        toExec.useRs1Pc         <= useRs1Pc;
        toExec.branchOnNotEqual <= funct3[0];
    end

endmodule

`default_nettype wire

// ==== logic/execStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module execStage import rvPkg::*; (
    input  logic    clk,
    input  logic    rst,
    decodeExecIf.exec fromDecode,
    execMemIf.exec    toMem,
    input  logic    wbWen,
    input  regAddrT wbRd,
    input  wordT    wbData,
    output logic    redirectValid,
    output wordT    redirectPc
);

    wordT fwdA;
    wordT fwdB;
    wordT opA;
    wordT opB;
    wordT aluOut;
    wordT result;
    logic [4:0] shamt;
    logic fwdMemA;
    logic fwdMemB;
    logic operandsEqual;

    // EX/MEM holds the newer value, so it is checked first.
    assign fwdMemA = toMem.regWrite && toMem.rd != '0 && toMem.rd == fromDecode.rs1;
    assign fwdMemB = toMem.regWrite && toMem.rd != '0 && toMem.rd == fromDecode.rs2;

    assign fwdA = fwdMemA ? toMem.result :
                  (wbWen && wbRd == fromDecode.rs1) ? wbData : fromDecode.rs1Val;
    assign fwdB = fwdMemB ? toMem.result :
                  (wbWen && wbRd == fromDecode.rs2) ? wbData : fromDecode.rs2Val;

    assign opA   = fromDecode.useRs1Pc ? fromDecode.pc : fwdA;
    assign opB   = fromDecode.useImm ? fromDecode.imm : fwdB;
    assign shamt = opB[4:0];

    always_comb begin
        case (fromDecode.aluOp)
            aluAdd:   aluOut = opA + opB;
            aluSub:   aluOut = opA - opB;
            aluSll:   aluOut = opA << shamt;
            aluSlt:   aluOut = wordT'($signed(opA) < $signed(opB));
            aluSltu:  aluOut = wordT'(opA < opB);
            aluXor:   aluOut = opA ^ opB;
            aluSrl:   aluOut = opA >> shamt;
            aluSra:   aluOut = wordT'($signed(opA) >>> shamt);
            aluOr:    aluOut = opA | opB;
            aluAnd:   aluOut = opA & opB;
            aluPassB: aluOut = opB;
            default:  aluOut = '0;
        endcase
    end

    // JAL links the return address.
    assign result = fromDecode.isJal ? fromDecode.pc + wordT'(4) : aluOut;

    assign operandsEqual = (fwdA == fwdB);

    assign redirectValid = fromDecode.valid
                           && (fromDecode.isJal
                               || (fromDecode.isBranch
                                   && (operandsEqual ^ fromDecode.branchOnNotEqual)));
    assign redirectPc = fromDecode.pc + fromDecode.imm;
    assign fromDecode.flush = redirectValid;

    always_ff @(posedge clk) begin
        if (rst) begin
            toMem.valid    <= 1'b0;
            toMem.regWrite <= 1'b0;
            toMem.isLoad   <= 1'b0;
            toMem.isStore  <= 1'b0;
        end else begin
            toMem.valid    <= fromDecode.valid;
            toMem.regWrite <= fromDecode.regWrite;
            toMem.isLoad   <= fromDecode.isLoad;
            toMem.isStore  <= fromDecode.isStore;
        end
    end

    always_ff @(posedge clk) begin
        toMem.pc        <= fromDecode.pc;
        toMem.rd        <= fromDecode.rd;
        toMem.result    <= result;
        toMem.storeData <= fwdB; // forwarded so a store sees the newest rs2.
    end

endmodule

`default_nettype wire

// ==== logic/memWbStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module memWbStage import rvPkg::*; (
    input  logic    clk,
    input  logic    rst,
    execMemIf.mem   fromExec,
    output wordT    dmemAddr,
    output wordT    dmemWrData,
    output logic    dmemWrEn,
    input  wordT    dmemRdData,
    output logic    wbWen,
    output regAddrT wbRd,
    output wordT    wbData,
    output logic    retireValid,
    output wordT    retirePc
);

    wordT memResult;

    assign dmemAddr   = fromExec.result;
    assign dmemWrData = fromExec.storeData;
    assign dmemWrEn   = fromExec.valid && fromExec.isStore;

    // data memory reads combinationally, so the load value is here this cycle.
    assign memResult = fromExec.isLoad ? dmemRdData : fromExec.result;

    always_ff @(posedge clk) begin
        if (rst) begin
            retireValid <= 1'b0;
            wbWen       <= 1'b0;
        end else begin
            retireValid <= fromExec.valid;
            wbWen       <= fromExec.valid && fromExec.regWrite && fromExec.rd != '0;
        end
    end

    always_ff @(posedge clk) begin
        retirePc <= fromExec.pc;
        wbRd     <= fromExec.rd;
        wbData   <= memResult;
    end

endmodule

`default_nettype wire

// ==== logic/pipelineCpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipelineCpu import rvPkg::*; (
    input  logic    clk,
    input  logic    rst,
    output wordT    imemAddr,
    input  wordT    imemData,
    output wordT    dmemAddr,
    output wordT    dmemWrData,
    output logic    dmemWrEn,
    input  wordT    dmemRdData,
    output logic    retireValid,
    output wordT    retirePc,
    output regAddrT retireRd,
    output logic    retireWen,
    output wordT    retireData
);

    wordT    fetchPc;
    wordT    fetchInst;
    logic    fetchValid;
    logic    stall;
    logic    redirectValid;
    wordT    redirectPc;
    logic    wbWen;
    regAddrT wbRd;
    wordT    wbData;

    decodeExecIf deBus ();
    execMemIf    emBus ();

    fetchStage uFetch (
        .clk           (clk),
        .rst           (rst),
        .stall         (stall),
        .redirectValid (redirectValid),
        .redirectPc    (redirectPc),
        .imemAddr      (imemAddr),
        .imemData      (imemData),
        .fetchPc       (fetchPc),
        .fetchInst     (fetchInst),
        .fetchValid    (fetchValid)
    );

    decodeStage uDecode (
        .clk           (clk),
        .rst           (rst),
        .fetchPc       (fetchPc),
        .fetchInst     (fetchInst),
        .fetchValid    (fetchValid),
        .stall         (stall),
        .redirectValid (redirectValid),
        .wbWen         (wbWen),
        .wbRd          (wbRd),
        .wbData        (wbData),
        .toExec        (deBus)
    );

    execStage uExec (
        .clk           (clk),
        .rst           (rst),
        .fromDecode    (deBus),
        .toMem         (emBus),
        .wbWen         (wbWen),
        .wbRd          (wbRd),
        .wbData        (wbData),
        .redirectValid (redirectValid),
        .redirectPc    (redirectPc)
    );

    memWbStage uMemWb (
        .clk         (clk),
        .rst         (rst),
        .fromExec    (emBus),
        .dmemAddr    (dmemAddr),
        .dmemWrData  (dmemWrData),
        .dmemWrEn    (dmemWrEn),
        .dmemRdData  (dmemRdData),
        .wbWen       (wbWen),
        .wbRd        (wbRd),
        .wbData      (wbData),
        .retireValid (retireValid),
        .retirePc    (retirePc)
    );

    // the retire report mirrors the register-file write of the same cycle.
    assign retireRd   = wbRd;
    assign retireWen  = wbWen;
    assign retireData = wbData;

endmodule

`default_nettype wire

// ==== dv/rvRefModel.svh ====
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

// integer operations of RV32I selected by funct3.
function automatic wordT aluReference(input logic [2:0] f3, input logic alt,
                                      input wordT a, input wordT b);
    case (f3)
        3'd0:    return alt ? a - b : a + b;
        3'd1:    return a << b[4:0];
        3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'd3:    return (a < b) ? 32'd1 : 32'd0;
        3'd4:    return a ^ b;
        3'd5:    return alt ? wordT'($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'd6:    return a | b;
        default: return a & b;
    endcase
endfunction

// executes one instruction on refRegs and refMem and returns the next pc.
function automatic wordT stepReference(input wordT pc, input wordT inst, output logic wen,
                                       output regAddrT rd, output wordT data);
    wordT a;
    wordT b;
    wordT immI;
    wordT addr;
    wordT nextPc;
    logic [2:0] f3;
    a      = refRegs[inst[19:15]];
    b      = refRegs[inst[24:20]];
    f3     = inst[14:12];
    immI   = {{20{inst[31]}}, inst[31:20]};
    rd     = inst[11:7];
    nextPc = pc + 32'd4;
    wen    = 1'b0;
    data   = '0;
    case (opcodeT'(inst[6:0]))
        OP: begin
            data = aluReference(f3, inst[30], a, b);
            wen  = 1'b1;
        end
        OP_IMM: begin
            data = aluReference(f3, (f3 == 3'd5) && inst[30], a, immI);
            wen  = 1'b1;
        end
        LUI: begin
            data = {inst[31:12], 12'b0};
            wen  = 1'b1;
        end
        AUIPC: begin
            data = pc + {inst[31:12], 12'b0};
            wen  = 1'b1;
        end
        LOAD: begin
            addr = a + immI;
            data = refMem[addr[9:2]];
            wen  = 1'b1;
        end
        STORE: begin
            addr = a + {{20{inst[31]}}, inst[31:25], inst[11:7]};
            refMem[addr[9:2]] = b;
        end
        BRANCH: begin
            if ((a == b) != inst[12]) begin // funct3 bit 0 selects BNE.
                nextPc = pc + {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            end
        end
        JAL: begin
            data   = pc + 32'd4;
            wen    = 1'b1;
            nextPc = pc + {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
        end
        default: begin
        end
    endcase
    wen = wen && (rd != '0);
    if (wen) begin
        refRegs[rd] = data;
    end
    return nextPc;
endfunction

`endif

// ==== dv/cpuTb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rvConsts.svh"

module cpuTb import rvPkg::*; ();

    logic clk = 1'b0;
    logic rst = 1'b1;
    wordT imemAddr, imemData, dmemAddr, dmemWrData, dmemRdData;
    logic dmemWrEn, retireValid, retireWen;
    wordT retirePc, retireData;
    regAddrT retireRd;
    wordT imem [256];
    wordT dmem [256];
    wordT refRegs [`RV_NUM_REGS];
    wordT refMem [256];
    wordT prog [$];
    wordT expPc [$];
    wordT expData [$];
    regAddrT expRd [$];
    logic expWen [$];
    string testName = "reset";
    integer seed = 32'h4221;
    int cycleBudget = 64;
    int cycleCount = 0;

    `include "rvRefModel.svh"

    pipelineCpu dut_i (
        .clk(clk), .rst(rst), .imemAddr(imemAddr), .imemData(imemData),
        .dmemAddr(dmemAddr), .dmemWrData(dmemWrData), .dmemWrEn(dmemWrEn),
        .dmemRdData(dmemRdData), .retireValid(retireValid), .retirePc(retirePc),
        .retireRd(retireRd), .retireWen(retireWen), .retireData(retireData)
    );

    assign imemData   = imem[imemAddr[9:2]];
    assign dmemRdData = dmem[dmemAddr[9:2]];

    always @(posedge clk) begin
        if (dmemWrEn) begin
            dmem[dmemAddr[9:2]] <= dmemWrData;
        end
    end

    initial begin
        forever #2 clk = ~clk;
    end

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1);
    endtask

    function automatic wordT iType(input int imm, input regAddrT rs1, input logic [2:0] f3,
                                   input regAddrT rd, input opcodeT op);
        logic [11:0] v;
        v = imm[11:0];
        return {v, rs1, f3, rd, 7'(op)};
    endfunction

    function automatic wordT rType(input logic alt, input regAddrT rs2, input regAddrT rs1,
                                   input logic [2:0] f3, input regAddrT rd);
        return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, 7'(OP)};
    endfunction

    function automatic wordT sw(input regAddrT rs2, input int off);
        logic [11:0] v;
        v = off[11:0];
        return {v[11:5], rs2, 5'd0, 3'b010, v[4:0], 7'(STORE)};
    endfunction

    function automatic wordT branch(input logic bne, input regAddrT rs1, input regAddrT rs2,
                                    input int off);
        logic [12:0] v;
        v = off[12:0];
        return {v[12], v[10:5], rs2, rs1, 2'b00, bne, v[4:1], v[11], 7'(BRANCH)};
    endfunction

    function automatic wordT jal(input regAddrT rd, input int off);
        logic [20:0] v;
        v = off[20:0];
        return {v[20], v[10:1], v[11], v[19:12], rd, 7'(JAL)};
    endfunction

    function automatic wordT addi(input regAddrT rd, input regAddrT rs1, input int imm);
        return iType(imm, rs1, 3'b000, rd, OP_IMM);
    endfunction

    function automatic wordT lw(input regAddrT rd, input int off);
        return iType(off, 5'd0, 3'b010, rd, LOAD);
    endfunction

    // every word depends on its full index.
    function automatic wordT memFill(input int i);
        return (wordT'(i) * 32'h9E37_79B1) ^ 32'h5A5A_0000;
    endfunction

    // each program opens by zeroing x1..x15, matching the all-zero reference registers.
    task automatic startProgram();
        prog.delete();
        for (int r = 1; r < 16; r++) begin
            prog.push_back(addi(regAddrT'(r), 5'd0, 0));
        end
    endtask

    task automatic runTest(input string name);
        wordT pc;
        wordT inst;
        logic wen;
        regAddrT rd;
        wordT data;
        int steps;
        @(posedge clk);
        #1 rst = 1'b1;
        testName = name;
        for (int i = 0; i < 256; i++) begin
            imem[i]   = (i < prog.size()) ? prog[i] : `RV_NOP;
            dmem[i]   = memFill(i);
            refMem[i] = memFill(i);
        end
        for (int r = 0; r < `RV_NUM_REGS; r++) begin
            refRegs[r] = '0;
        end
        pc    = `RV_RESET_PC;
        steps = 0;
        while ((pc >> 2) < prog.size() && steps < 1000) begin
            inst = prog[pc >> 2];
            expPc.push_back(pc);
            pc = stepReference(pc, inst, wen, rd, data);
            expWen.push_back(wen);
            expRd.push_back(rd);
            expData.push_back(data);
            steps++;
        end
        cycleBudget += 6 * prog.size() + 24;
        repeat (16) @(posedge clk);
        #1 rst = 1'b0;
        while (expPc.size() != 0) begin
            @(posedge clk);
        end
        for (int i = 0; i < 256; i++) begin
            assert (dmem[i] == refMem[i]) else
                failRun($sformatf("Error %s dmem[%0d] expected %h actual %h",
                                  name, i, refMem[i], dmem[i]));
        end
    endtask

    // retire outputs change at the rising edge, so they are read at the falling one.
    always @(negedge clk) begin
        if (!rst && retireValid && expPc.size() != 0) begin
            assert (retirePc == expPc[0]) else
                failRun($sformatf("Error %s retire pc expected %h actual %h",
                                  testName, expPc[0], retirePc));
            assert (retireWen == expWen[0]) else
                failRun($sformatf("Error %s write enable at pc %h expected %b actual %b",
                                  testName, retirePc, expWen[0], retireWen));
            if (expWen[0]) begin
                assert (retireRd == expRd[0] && retireData == expData[0]) else
                    failRun($sformatf("Error %s pc %h expected x%0d=%h actual x%0d=%h",
                                      testName, retirePc, expRd[0], expData[0],
                                      retireRd, retireData));
            end
            void'(expPc.pop_front());
            void'(expWen.pop_front());
            void'(expRd.pop_front());
            void'(expData.pop_front());
        end
    end

    initial begin
        forever begin
            @(posedge clk);
            cycleCount++;
            if (cycleCount > cycleBudget) begin
                failRun($sformatf("Timeout in %s: the CPU stopped retiring instructions.",
                                  testName));
            end
        end
    end

    task automatic buildRandomProgram();
        int r;
        logic [2:0] f3;
        regAddrT rd, rs1, rs2;
        startProgram();
        for (int n = 0; n < 200; n++) begin
            r   = $random(seed);
            f3  = r[10:8];
            rd  = {2'b00, r[13:11]};
            rs1 = {2'b00, r[16:14]};
            rs2 = {2'b00, r[19:17]};
            case (r[2:0])
                3'd0, 3'd1: prog.push_back(rType((f3 == 3'd0 || f3 == 3'd5) && r[20],
                                                 rs2, rs1, f3, rd));
                3'd2, 3'd3: begin
                    if (f3 == 3'd1 || f3 == 3'd5) begin
                        prog.push_back(iType(
                            int'({(f3 == 3'd5 && r[20]) ? 7'h20 : 7'h00, r[25:21]}),
                            rs1, f3, rd, OP_IMM));
                    end else begin
                        prog.push_back(iType(int'(r[31:20]), rs1, f3, rd, OP_IMM));
                    end
                end
                3'd4, 3'd5: prog.push_back(lw(rd, int'({r[24:21], 2'b00})));
                default:    prog.push_back(sw(rs2, int'({r[24:21], 2'b00})));
            endcase
        end
    endtask

    initial begin
        startProgram();
        prog.push_back(addi(1, 0, 5));
        prog.push_back(addi(2, 1, 7));
        prog.push_back(rType(0, 1, 2, 3'b000, 3));
        prog.push_back(rType(1, 1, 3, 3'b000, 4));
        prog.push_back(rType(0, 2, 4, 3'b100, 5));
        prog.push_back(rType(0, 1, 5, 3'b001, 6));
        prog.push_back(addi(7, 0, -100));
        prog.push_back(iType('h402, 7, 3'b101, 8, OP_IMM)); // srai by 2.
        prog.push_back(iType(3, 7, 3'b101, 12, OP_IMM));
        prog.push_back(rType(0, 1, 7, 3'b010, 9));
        prog.push_back(rType(0, 1, 7, 3'b011, 10));
        prog.push_back(rType(0, 6, 8, 3'b110, 13));
        prog.push_back(rType(0, 13, 4, 3'b111, 14));
        prog.push_back(addi(0, 1, 9));
        prog.push_back(rType(0, 1, 0, 3'b000, 11));
        runTest("aluChain");

        startProgram();
        prog.push_back(addi(1, 0, 42));
        prog.push_back(sw(1, 8));
        prog.push_back(lw(2, 8));
        prog.push_back(rType(0, 2, 2, 3'b000, 3));
        prog.push_back(lw(4, 12));
        prog.push_back(addi(5, 4, 1));
        prog.push_back(lw(6, 8));
        prog.push_back(sw(6, 16));
        prog.push_back(lw(7, 16));
        prog.push_back(rType(1, 1, 7, 3'b000, 8));
        runTest("loadUse");

        startProgram();
        prog.push_back(addi(1, 0, 100));
        prog.push_back(addi(2, 0, -7));
        prog.push_back(sw(1, 0));
        prog.push_back(sw(2, 4));
        prog.push_back(lw(3, 0));
        prog.push_back(lw(4, 20));
        prog.push_back(sw(4, 0));
        prog.push_back(sw(3, 40));
        prog.push_back(lw(5, 4));
        prog.push_back(lw(6, 0));
        runTest("memory");

        startProgram();
        prog.push_back(addi(1, 0, 3));
        prog.push_back(addi(2, 0, 3));
        prog.push_back(branch(0, 1, 2, 12));
        prog.push_back(addi(3, 0, 1));
        prog.push_back(addi(3, 0, 2));
        prog.push_back(branch(1, 1, 2, 8));
        prog.push_back(addi(4, 0, 4));
        prog.push_back(branch(1, 1, 0, 12));
        prog.push_back(addi(5, 0, 5));
        prog.push_back(addi(5, 0, 6));
        prog.push_back(jal(6, 12));
        prog.push_back(addi(7, 0, 7));
        prog.push_back(addi(7, 0, 8));
        prog.push_back(addi(8, 6, 1));
        prog.push_back(branch(0, 1, 0, 8));
        prog.push_back(rType(0, 4, 8, 3'b000, 9));
        prog.push_back(branch(0, 9, 9, 8));
        prog.push_back(addi(10, 0, 1));
        prog.push_back(addi(11, 9, 0));
        runTest("control");

        startProgram();
        prog.push_back({20'h12345, 5'd1, 7'(LUI)});
        prog.push_back({20'h00001, 5'd2, 7'(AUIPC)});
        prog.push_back(addi(3, 1, 'h678));
        prog.push_back({20'h00000, 5'd4, 7'(AUIPC)});
        prog.push_back(rType(0, 2, 4, 3'b000, 5));
        runTest("luiAuipc");

        buildRandomProgram();
        runTest("randomProgram");

        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+logic
+incdir+dv
logic/rvPkg.sv
logic/stageIf.sv
logic/fetchStage.sv
logic/decodeStage.sv
logic/execStage.sv
logic/memWbStage.sv
logic/pipelineCpu.sv
dv/cpuTb.sv

// ==== Makefile ====
SRCS := all.f $(wildcard logic/*.sv logic/*.svh dv/*.sv dv/*.svh)

.PHONY: all run clean

all: obj_dir/VcpuTb

obj_dir/VcpuTb: $(SRCS)
	verilator --binary -f all.f --top-module cpuTb -o VcpuTb

run: obj_dir/VcpuTb
	./obj_dir/VcpuTb | tee /dev/stderr | grep -q "^test passed$$"

clean:
	rm -rf obj_dir
